/* hw/rv_decode_cfg.svh */
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// ##################################################
// Decode stage sizing
// ##################################################

// Instruction word and immediate width
`define XLEN 32

// The branch tag wraps modulo 2**BRTAG_W
`define BRTAG_W 6

`endif

/* hw/rv_decode_pkg.sv */
`default_nettype none

`include "rv_decode_cfg.svh"

package rv_decode_pkg;

	// ##################################################
	// Encodings
	// ##################################################

	typedef enum logic [2:0] {
		NONE = 3'd0,
		R    = 3'd1,
		I    = 3'd2,
		S    = 3'd3,
		B    = 3'd4,
		U    = 3'd5,
		J    = 3'd6
	} imm_fmt_e;

	typedef enum logic [1:0] {
		Q_NONE = 2'b00,
		Q_MEM  = 2'b01,
		Q_ALU  = 2'b10
	} queue_e;

	// ##################################################
	// Payloads
	// ##################################################

	typedef struct packed {
		logic [`XLEN-1:0] instr;
	} fetch_pkt_t;

	typedef struct packed {
		logic [6:0]          opcode;
		logic [4:0]          rd;
		logic [4:0]          rs1;
		logic [4:0]          rs2;
		logic [9:0]          func;   // Funct7 then funct3
		logic [`XLEN-1:0]    imm;
		logic [1:0]          prio;
		queue_e              queue;
		logic                is_cti; // Branch or jump
		logic [`BRTAG_W-1:0] brtag;
	} uop_t;

endpackage

`default_nettype wire

/* hw/uop_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Decoded uop travelling from the decoder to the dispatch router
interface uop_if;

	logic                valid;  // One uop per high cycle
	logic                is_cti; // Qualified by valid, feeds the tag counter
	rv_decode_pkg::uop_t uop;

	modport producer
	(
		output valid,
		output is_cti,
		output uop
	);

	modport consumer
	(
		input valid,
		input uop
	);

endinterface

`default_nettype wire

/* hw/stage_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
	parameter type T = logic
) (
	input  wire  i_clk,
	input  wire  i_rst,
	input  wire  i_valid,
	input  wire T i_data,
	output logic o_valid,
	output T     o_data
);

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_valid)
			o_data <= i_data; // Payload only moves with a valid beat
	end

	a_clear_after_reset: assert property (@(posedge i_clk) i_rst |=> !o_valid)
		else $error("stage_reg valid set in the cycle after reset");

endmodule

`default_nettype wire

/* hw/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_cfg.svh"

module imm_gen (
	input  wire [6:0]          i_opcode,
	input  wire [`XLEN-8:0]    i_instr_hi, // Instruction bits 31 down to 7
	output rv_decode_pkg::imm_fmt_e o_fmt,
	output logic [`XLEN-1:0]   o_imm
);

	logic sign;

	assign sign = i_instr_hi[24]; // Instruction bit 31

	// ##################################################
	// Format from the major opcode
	// ##################################################

	always_comb
	begin
		case (i_opcode)
			7'b0110011: o_fmt = rv_decode_pkg::R;
			7'b0010011: o_fmt = rv_decode_pkg::I; // ALU immediate
			7'b0000011: o_fmt = rv_decode_pkg::I; // Load
			7'b1100111: o_fmt = rv_decode_pkg::I; // JALR
			7'b0100011: o_fmt = rv_decode_pkg::S;
			7'b1100011: o_fmt = rv_decode_pkg::B;
			7'b0110111: o_fmt = rv_decode_pkg::U; // LUI
			7'b0010111: o_fmt = rv_decode_pkg::U; // AUIPC
			7'b1101111: o_fmt = rv_decode_pkg::J;
			default:    o_fmt = rv_decode_pkg::NONE;
		endcase
	end

	// ##################################################
	// Immediate assembly
	// ##################################################

	// Offsets below are instruction bit minus seven
	always_comb
	begin
		case (o_fmt)
			rv_decode_pkg::I:
				o_imm = {{20{sign}}, i_instr_hi[24:13]};
			rv_decode_pkg::S:
				o_imm = {{20{sign}}, i_instr_hi[24:18], i_instr_hi[4:0]};
			rv_decode_pkg::B:
				o_imm = {{20{sign}}, i_instr_hi[0], i_instr_hi[23:18],
				         i_instr_hi[4:1], 1'b0};
			rv_decode_pkg::U:
				o_imm = {i_instr_hi[24:5], 12'b0};
			rv_decode_pkg::J:
				o_imm = {{12{sign}}, i_instr_hi[12:5], i_instr_hi[13],
				         i_instr_hi[23:14], 1'b0};
			default:
				o_imm = '0; // R format and unknown opcodes carry no immediate
		endcase
	end

endmodule

`default_nettype wire

/* hw/rv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_cfg.svh"

module rv_decode (
	input  wire                       i_valid,
	input  wire rv_decode_pkg::fetch_pkt_t i_instr,
	input  wire [`BRTAG_W-1:0]        i_brtag,
	uop_if.producer                   uop
);

	logic [6:0]               opcode;
	logic [4:0]               rd;
	logic [4:0]               rs1;
	logic [4:0]               rs2;
	logic [2:0]               funct3;
	logic [6:0]               funct7;
	logic [1:0]               prio;
	logic                     cti;
	logic [`XLEN-1:0]         imm;
	rv_decode_pkg::imm_fmt_e  fmt;
	rv_decode_pkg::queue_e    queue;

	assign opcode = i_instr.instr[6:0];

	imm_gen u_imm_gen (
		.i_opcode   (opcode),
		.i_instr_hi (i_instr.instr[`XLEN-1:7]),
		.o_fmt      (fmt),
		.o_imm      (imm)
	);

	// Branches, JAL and JALR
	always_comb
	begin
		case (opcode)
			7'b1100011: cti = 1'b1;
			7'b1101111: cti = 1'b1;
			7'b1100111: cti = 1'b1;
			default:    cti = 1'b0;
		endcase
	end

	assign prio = cti ? 2'b11 : 2'b00; // Control transfers issue first

	// ##################################################
	// Register and function masking by format
	// ##################################################

	always_comb
	begin
		rd     = 5'b0;
		rs1    = 5'b0;
		rs2    = 5'b0;
		funct7 = 7'b0;
		funct3 = 3'b0;
		case (fmt)
			rv_decode_pkg::R:
			begin
				rd     = i_instr.instr[11:7];
				rs1    = i_instr.instr[19:15];
				rs2    = i_instr.instr[24:20];
				funct7 = i_instr.instr[31:25];
				funct3 = i_instr.instr[14:12];
			end
			rv_decode_pkg::I:
			begin
				rd     = i_instr.instr[11:7];
				rs1    = i_instr.instr[19:15];
				funct3 = i_instr.instr[14:12]; // Shift funct7 is left to the ALU queue
			end
			rv_decode_pkg::S, rv_decode_pkg::B:
			begin
				rs1    = i_instr.instr[19:15];
				rs2    = i_instr.instr[24:20];
				funct3 = i_instr.instr[14:12];
			end
			rv_decode_pkg::U, rv_decode_pkg::J:
				rd = i_instr.instr[11:7];
			default:
				rd = 5'b0;
		endcase
	end

	// Loads and stores go to memory, everything else to the ALU
	always_comb
	begin
		if (!i_valid)
			queue = rv_decode_pkg::Q_NONE;
		else if (opcode ==? 7'b0?00011)
			queue = rv_decode_pkg::Q_MEM;
		else
			queue = rv_decode_pkg::Q_ALU;
	end

	assign uop.valid  = i_valid;
	assign uop.is_cti = i_valid && cti;

	assign uop.uop.opcode = opcode;
	assign uop.uop.rd     = rd;
	assign uop.uop.rs1    = rs1;
	assign uop.uop.rs2    = rs2;
	assign uop.uop.func   = {funct7, funct3};
	assign uop.uop.imm    = imm;
	assign uop.uop.prio   = prio;
	assign uop.uop.queue  = queue;
	assign uop.uop.is_cti = cti;
	assign uop.uop.brtag  = i_brtag;

endmodule

`default_nettype wire

/* hw/branch_tag_counter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_cfg.svh"

module branch_tag_counter (
	input  wire                 i_clk,
	input  wire                 i_rst,
	input  wire                 i_valid,
	input  wire                 i_is_cti,
	output logic [`BRTAG_W-1:0] o_brtag
);

	logic [`BRTAG_W-1:0] r_count;

	// A control transfer sees the tag it opens, others see the current one
	assign o_brtag = i_is_cti ? r_count + `BRTAG_W'(1) : r_count;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			r_count <= '0;
		else if (i_valid)
			r_count <= o_brtag; // Wraps naturally at the tag width
	end

	a_hold_when_idle: assert property (
		@(posedge i_clk) disable iff (i_rst)
		!i_valid |=> $stable(r_count))
		else $error("Branch tag moved without a valid uop");

endmodule

`default_nettype wire

/* hw/dispatch_router.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_router (
	input  wire                  i_clk,
	input  wire                  i_rst,
	uop_if.consumer              uop,
	output rv_decode_pkg::uop_t  o_uop,
	output logic                 o_mem_valid,
	output logic                 o_alu_valid
);

	logic r_valid;

	stage_reg #(
		.T (rv_decode_pkg::uop_t)
	) u_uop_reg (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_valid (uop.valid),
		.i_data  (uop.uop),
		.o_valid (r_valid),
		.o_data  (o_uop)
	);

	// ##################################################
	// Queue strobes
	// ##################################################

	assign o_mem_valid = r_valid && (o_uop.queue == rv_decode_pkg::Q_MEM);
	assign o_alu_valid = r_valid && (o_uop.queue == rv_decode_pkg::Q_ALU);

	a_strobe_exclusive: assert property (
		@(posedge i_clk) disable iff (i_rst)
		!(o_mem_valid && o_alu_valid))
		else $error("Memory and ALU strobes high together");

	// A registered uop must have been given a real queue by the decoder
	a_strobe_per_uop: assert property (
		@(posedge i_clk) disable iff (i_rst)
		r_valid |-> (o_mem_valid || o_alu_valid))
		else $error("Valid uop without a queue strobe");

endmodule

`default_nettype wire

/* hw/decode_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_cfg.svh"

module decode_top (
	input  wire                 i_clk,
	input  wire                 i_rst,
	input  wire                 i_valid,
	input  wire [`XLEN-1:0]     i_instr,
	output logic                o_mem_valid,
	output logic                o_alu_valid,
	output logic [6:0]          o_opcode,
	output logic [4:0]          o_rd,
	output logic [4:0]          o_rs1,
	output logic [4:0]          o_rs2,
	output logic [9:0]          o_func,
	output logic [`XLEN-1:0]    o_imm,
	output logic [1:0]          o_prio,
	output logic [`BRTAG_W-1:0] o_brtag
);

	rv_decode_pkg::fetch_pkt_t fetch_in;
	rv_decode_pkg::fetch_pkt_t fetch_q;
	logic                      fetch_valid;
	logic [`BRTAG_W-1:0]       brtag;
	rv_decode_pkg::uop_t       uop_q;

	uop_if u_uop_if ();

	assign fetch_in.instr = i_instr;

	// ##################################################
	// Fetch register, decode, tag, dispatch
	// ##################################################

	stage_reg #(
		.T (rv_decode_pkg::fetch_pkt_t)
	) u_fetch_reg (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_valid (i_valid),
		.i_data  (fetch_in),
		.o_valid (fetch_valid),
		.o_data  (fetch_q)
	);

	rv_decode u_rv_decode (
		.i_valid (fetch_valid),
		.i_instr (fetch_q),
		.i_brtag (brtag),
		.uop     (u_uop_if.producer)
	);

	branch_tag_counter u_branch_tag_counter (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_valid  (u_uop_if.valid),
		.i_is_cti (u_uop_if.is_cti),
		.o_brtag  (brtag)
	);

	dispatch_router u_dispatch_router (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.uop         (u_uop_if.consumer),
		.o_uop       (uop_q),
		.o_mem_valid (o_mem_valid),
		.o_alu_valid (o_alu_valid)
	);

	assign o_opcode = uop_q.opcode;
	assign o_rd     = uop_q.rd;
	assign o_rs1    = uop_q.rs1;
	assign o_rs2    = uop_q.rs2;
	assign o_func   = uop_q.func;
	assign o_imm    = uop_q.imm;
	assign o_prio   = uop_q.prio;
	assign o_brtag  = uop_q.brtag;

endmodule

`default_nettype wire

/* verif/tb_decode_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_cfg.svh"

module tb_decode_top;

	localparam int MAX_UOPS = 256;

	logic                clk;
	logic                rst;
	logic                valid;
	logic [`XLEN-1:0]    instr;
	logic                mem_valid;
	logic                alu_valid;
	logic [6:0]          opcode;
	logic [4:0]          rd;
	logic [4:0]          rs1;
	logic [4:0]          rs2;
	logic [9:0]          func;
	logic [`XLEN-1:0]    imm;
	logic [1:0]          prio;
	logic [`BRTAG_W-1:0] brtag;

	string       names [MAX_UOPS];
	int          gaps [MAX_UOPS];
	logic [31:0] instrs [MAX_UOPS];
	logic [31:0] exp_queue [MAX_UOPS];
	logic [31:0] exp_opcode [MAX_UOPS];
	logic [31:0] exp_rd [MAX_UOPS];
	logic [31:0] exp_rs1 [MAX_UOPS];
	logic [31:0] exp_rs2 [MAX_UOPS];
	logic [31:0] exp_func [MAX_UOPS];
	logic [31:0] exp_imm [MAX_UOPS];
	logic [31:0] exp_prio [MAX_UOPS];
	logic [31:0] exp_brtag [MAX_UOPS];
	int          num_uops;
	int          gap_total;
	int          num_seen;
	int          errors;
	int          cycle;
	int          in_cycles [$]; // Cycle in which each input strobe was seen
	logic        loaded;

	decode_top DUT (
		.i_clk       (clk),
		.i_rst       (rst),
		.i_valid     (valid),
		.i_instr     (instr),
		.o_mem_valid (mem_valid),
		.o_alu_valid (alu_valid),
		.o_opcode    (opcode),
		.o_rd        (rd),
		.o_rs1       (rs1),
		.o_rs2       (rs2),
		.o_func      (func),
		.o_imm       (imm),
		.o_prio      (prio),
		.o_brtag     (brtag)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// ##################################################
	// Test table
	// ##################################################

	// Each line expands into rep uops, a control transfer steps the tag per repeat
	task automatic load_tests();
		int          fd;
		int          k;
		int          gap;
		int          rep;
		int          q;
		int          pr;
		int          tag;
		string       name;
		logic [31:0] word;
		logic [31:0] op;
		logic [31:0] f_rd;
		logic [31:0] f_rs1;
		logic [31:0] f_rs2;
		logic [31:0] f_func;
		logic [31:0] f_imm;
		fd = $fopen("verif/decode_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the test table verif/decode_tests.txt");
			errors++;
			return;
		end
		while ($fscanf(fd, "%s %d %d %h %d %h %h %h %h %h %h %d %d", name, gap, rep, word,
			q, op, f_rd, f_rs1, f_rs2, f_func, f_imm, pr, tag) == 13)
		begin
			for (k = 0; k < rep && num_uops < MAX_UOPS; k++)
			begin
				names[num_uops]      = (rep > 1) ? $sformatf("%s_%0d", name, k) : name;
				gaps[num_uops]       = (k == 0) ? gap : 0;
				instrs[num_uops]     = word;
				exp_queue[num_uops]  = q;
				exp_opcode[num_uops] = op;
				exp_rd[num_uops]     = f_rd;
				exp_rs1[num_uops]    = f_rs1;
				exp_rs2[num_uops]    = f_rs2;
				exp_func[num_uops]   = f_func;
				exp_imm[num_uops]    = f_imm;
				exp_prio[num_uops]   = pr;
				exp_brtag[num_uops]  = (pr == 3) ? (tag + k) % (1 << `BRTAG_W) : tag;
				gap_total            = gap_total + gaps[num_uops];
				num_uops++;
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_tests();
		int k;
		int g;
		for (k = 0; k < num_uops; k++)
		begin
			for (g = 0; g < gaps[k]; g++)
			begin
				@(posedge clk);
				valid <= 1'b0;
			end
			@(posedge clk);
			valid <= 1'b1;
			instr <= instrs[k];
		end
		@(posedge clk);
		valid <= 1'b0;
	endtask

	// ##################################################
	// Checking
	// ##################################################

	task automatic check_field(input string test, input string field,
		input logic [31:0] exp, input logic [31:0] act);
		assert (exp == act)
		else
		begin
			$display("FAIL %s %s expected %h actual %h", test, field, exp, act);
			errors++;
		end
	endtask

	task automatic check_uop();
		int k;
		int start;
		k = num_seen;
		num_seen++;
		if (k >= num_uops || in_cycles.size() == 0)
		begin
			$display("Queue strobe at cycle %0d has no matching input", cycle);
			errors++;
			return;
		end
		start = in_cycles.pop_front();
		check_field(names[k], "latency", 32'(start + 2), 32'(cycle));
		check_field(names[k], "queue", exp_queue[k], 32'({alu_valid, mem_valid}));
		check_field(names[k], "opcode", exp_opcode[k], 32'(opcode));
		check_field(names[k], "rd", exp_rd[k], 32'(rd));
		check_field(names[k], "rs1", exp_rs1[k], 32'(rs1));
		check_field(names[k], "rs2", exp_rs2[k], 32'(rs2));
		check_field(names[k], "func", exp_func[k], 32'(func));
		check_field(names[k], "imm", exp_imm[k], 32'(imm));
		check_field(names[k], "prio", exp_prio[k], 32'(prio));
		check_field(names[k], "brtag", exp_brtag[k], 32'(brtag));
	endtask

	// Sampled away from the rising edge so inputs and outputs are settled
	always @(negedge clk)
	begin
		if (valid && !rst)
			in_cycles.push_back(cycle);
		if (mem_valid || alu_valid)
			check_uop();
	end

	initial
	begin
		wait (loaded);
		#((num_uops + gap_total + 20) * 8);
		$display("Timeout after %0d cycles with %0d of %0d uops seen", cycle, num_seen, num_uops);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		clk       = 1'b0;
		rst       = 1'b1;
		valid     = 1'b1; // A strobe held through reset must never reach a queue
		instr     = '0;
		cycle     = 0;
		num_uops  = 0;
		gap_total = 0;
		num_seen  = 0;
		errors    = 0;
		loaded    = 1'b0;
		load_tests();
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		rst   <= 1'b0;
		valid <= 1'b0;
		drive_tests();
		wait (num_seen >= num_uops);
		repeat (4) @(posedge clk); // Room for any extra strobe to show up
		assert (num_seen == num_uops)
		else
		begin
			$display("Saw %0d queue strobes for %0d inputs", num_seen, num_uops);
			errors++;
		end
		$display("Done with %0d errors, %0d strobes for %0d inputs", errors, num_seen, num_uops);
		if (errors == 0 && num_uops > 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* decode_top.f */
+incdir+hw
hw/rv_decode_pkg.sv
hw/uop_if.sv
hw/stage_reg.sv
hw/imm_gen.sv
hw/rv_decode.sv
hw/branch_tag_counter.sv
hw/dispatch_router.sv
hw/decode_top.sv
verif/tb_decode_top.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_decode_top -f decode_top.f -o sim_decode_top

out=$(./obj_dir/sim_decode_top)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1

/* verif/decode_tests.txt */
add_r      0  1 002081b3 2 33 03 01 02 000 00000000 0 0
sub_r      0  1 407302b3 2 33 05 06 07 100 00000000 0 0
addi_neg   2  1 ffb58513 2 13 0a 0b 00 000 fffffffb 0 0
andi_max   0  1 7ff47213 2 13 04 08 00 007 000007ff 0 0
lw_neg     1  1 ffc12303 1 03 06 02 00 002 fffffffc 0 0
sw_pos     0  1 0051a423 1 23 00 03 05 002 00000008 0 0
sb_neg     3  1 fe920fa3 1 23 00 04 09 000 ffffffff 0 0
lui_hi     0  1 abcde3b7 2 37 07 00 00 000 abcde000 0 0
auipc_pos  0  1 00001097 2 17 01 00 00 000 00001000 0 0
beq_neg    0  1 fe208ce3 2 63 00 01 02 000 fffffff8 3 1
jal_pos    1  1 001000ef 2 6f 01 00 00 000 00000800 3 2
jal_neg    0  1 ffdff06f 2 6f 00 00 00 000 fffffffc 3 3
jalr_pos   0  1 010280e7 2 67 01 05 00 000 00000010 3 4
bad_ones   2  1 ffffffff 2 7f 00 00 00 000 00000000 0 4
bad_custom 0  1 0000000b 2 0b 00 00 00 000 00000000 0 4
nop        0  1 00000013 2 13 00 00 00 000 00000000 0 4
beq_wrap   1 64 00000263 2 63 00 00 00 000 00000004 3 5
or_regs    0  1 01df6fb3 2 33 1f 1e 1d 006 00000000 0 4
jalr_neg   0  1 80008067 2 67 00 01 00 000 fffff800 3 5
lbu_zero   0  1 0000c103 1 03 02 01 00 004 00000000 0 5
sh_max     2  1 7e209fa3 1 23 00 01 02 001 000007ff 0 5
bge_max    0  1 7e41dfe3 2 63 00 03 04 005 00000ffe 3 6
lui_ones   0  1 ffffffb7 2 37 1f 00 00 000 fffff000 0 6
